//--- common/vex_pkg.sv
package vex_pkg;

    // lane and register file geometry
    localparam int num_lanes  = 4;
    localparam int num_vregs  = 8;
    localparam int vreg_idx_w = 3;

    // 32-bit elements only
    localparam int word_w = 32;

    // vl counts 0 to num_lanes
    localparam int vl_w = 3;

    // nine opcodes need four bits
    localparam int vop_w = 4;

    typedef logic [word_w-1:0] word_t;

    typedef enum logic [vop_w-1:0] {
        // element-wise arithmetic and logic
        vop_add    = 4'd0,
        vop_sub    = 4'd1,
        vop_and    = 4'd2,
        vop_or     = 4'd3,
        vop_xor    = 4'd4,

        // compares write 1 or 0 per element
        vop_seq    = 4'd5,
        vop_slt    = 4'd6,

        // scalar broadcast
        vop_mv_x   = 4'd7,

        // sum of active vs2 lanes plus scalar into lane 0
        vop_redsum = 4'd8
    } vop_t;

endpackage

//--- source/vector_bank.sv
module vector_bank (
    input  logic                            CLK,
    input  logic                            rst_n,
    input  logic [vex_pkg::vreg_idx_w-1:0]  rd_sel1,
    input  logic [vex_pkg::vreg_idx_w-1:0]  rd_sel2,
    input  logic                            wr_en,
    input  logic [vex_pkg::vreg_idx_w-1:0]  wr_sel,
    input  vex_pkg::word_t                  wr_data,
    output vex_pkg::word_t                  rd_data1,
    output vex_pkg::word_t                  rd_data2,
    output vex_pkg::word_t                  v0_data
);

    import vex_pkg::*;

    // this lane's element of every vector register
    word_t regs [num_vregs];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_vregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // combinational reads
    assign rd_data1 = regs[rd_sel1];
    assign rd_data2 = regs[rd_sel2];

    // v0 always visible for masking
    assign v0_data = regs[0];

endmodule

//--- source/vector_mask_unit.sv
module vector_mask_unit (
    input  logic [vex_pkg::vl_w-1:0]       vl,
    input  logic                           mask_en,
    input  logic [vex_pkg::num_lanes-1:0]  v0_bits,
    input  logic                           is_reduction,
    output logic [vex_pkg::num_lanes-1:0]  lane_mask,
    output logic [vex_pkg::num_lanes-1:0]  reduce_mask
);

    import vex_pkg::*;

    logic [num_lanes-1:0] vl_mask;

    // lane i is in range when i < vl
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            vl_mask[i] = (vl > i);
        end
    end

    assign reduce_mask = mask_en ? (vl_mask & v0_bits) : vl_mask;

    // reductions write lane 0 only and ignore v0
    assign lane_mask = is_reduction ? {{(num_lanes-1){1'b0}}, vl_mask[0]} : reduce_mask;

endmodule

//--- execute/vector_lane_alu.sv
module vector_lane_alu (
    input  vex_pkg::vop_t   op,
    input  vex_pkg::word_t  op_a,
    input  vex_pkg::word_t  op_b,
    output vex_pkg::word_t  result
);

    import vex_pkg::*;

    always_comb begin
        case (op)
            vop_add: begin
                result = op_a + op_b;
            end
            vop_sub: begin
                // vs2 - vs1
                result = op_a - op_b;
            end
            vop_and: begin
                result = op_a & op_b;
            end
            vop_or: begin
                result = op_a | op_b;
            end
            vop_xor: begin
                result = op_a ^ op_b;
            end
            vop_seq: begin
                result = (op_a == op_b) ? word_t'(1) : '0;
            end
            vop_slt: begin
                result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            end
            vop_mv_x: begin
                result = op_b;
            end
            default: begin
                // redsum lane 0 gets replaced by the reduction sum
                result = op_a;
            end
        endcase
    end

endmodule

//--- execute/vector_reduction.sv
module vector_reduction (
    input  vex_pkg::word_t [vex_pkg::num_lanes-1:0]  lane_data,
    input  logic [vex_pkg::num_lanes-1:0]            active,
    input  vex_pkg::word_t                           seed,
    output vex_pkg::word_t                           sum
);

    import vex_pkg::*;

    word_t acc;

    // wraps modulo 2^32
    always_comb begin
        acc = seed;
        for (int i = 0; i < num_lanes; i++) begin
            if (active[i]) begin
                acc = acc + lane_data[i];
            end
        end
    end

    assign sum = acc;

endmodule

//--- execute/vector_ex_datapath.sv
module vector_ex_datapath (
    input  logic                                     CLK,
    input  logic                                     rst_n,

    input  logic                                     issue_valid,
    output logic                                     issue_ready,
    input  vex_pkg::vop_t                            issue_op,
    input  logic [vex_pkg::vreg_idx_w-1:0]           issue_vs1,
    input  logic [vex_pkg::vreg_idx_w-1:0]           issue_vs2,
    input  logic [vex_pkg::vreg_idx_w-1:0]           issue_vd,
    input  logic                                     issue_use_scalar,
    input  vex_pkg::word_t                           issue_scalar,
    input  logic                                     issue_mask_en,
    input  logic [vex_pkg::vl_w-1:0]                 vl,

    output logic                                     wb_valid,
    output logic [vex_pkg::vreg_idx_w-1:0]           wb_vd,
    output vex_pkg::word_t [vex_pkg::num_lanes-1:0]  wb_data,
    output logic [vex_pkg::num_lanes-1:0]            wb_lane_mask,
    input  logic                                     out_ready
);

    import vex_pkg::*;

    word_t [num_lanes-1:0] bank_rd1;
    word_t [num_lanes-1:0] bank_rd2;
    word_t [num_lanes-1:0] bank_v0;
    word_t [num_lanes-1:0] src1;
    word_t [num_lanes-1:0] src2;
    word_t [num_lanes-1:0] op_b;
    word_t [num_lanes-1:0] alu_res;
    word_t [num_lanes-1:0] lane_res;

    logic [num_lanes-1:0] v0_bits;
    logic [num_lanes-1:0] lane_mask;
    logic [num_lanes-1:0] reduce_mask;
    logic [num_lanes-1:0] bank_wr_en;

    word_t red_sum;
    logic  is_reduction;
    logic  issue_fire;
    logic  wb_fire;
    logic  fwd_vs1;
    logic  fwd_vs2;
    logic  fwd_v0;
    logic  run_q;

    // stall-style ready held low until the first edge after reset
    assign issue_ready = run_q & (~wb_valid | out_ready);
    assign issue_fire  = issue_valid & issue_ready;
    assign wb_fire     = wb_valid & out_ready;

    assign is_reduction = (issue_op == vop_redsum);

    // result being written this edge overrides the bank read
    assign fwd_vs1 = wb_fire && (wb_vd == issue_vs1);
    assign fwd_vs2 = wb_fire && (wb_vd == issue_vs2);
    assign fwd_v0  = wb_fire && (wb_vd == '0);

    assign bank_wr_en = {num_lanes{wb_fire}} & wb_lane_mask;

    for (genvar i = 0; i < num_lanes; i++) begin : lane_g
        vector_bank vector_bank_i (
            .CLK      (CLK),
            .rst_n    (rst_n),
            .rd_sel1  (issue_vs1),
            .rd_sel2  (issue_vs2),
            .wr_en    (bank_wr_en[i]),
            .wr_sel   (wb_vd),
            .wr_data  (wb_data[i]),
            .rd_data1 (bank_rd1[i]),
            .rd_data2 (bank_rd2[i]),
            .v0_data  (bank_v0[i])
        );

        // merged value takes new lanes only where the result mask is set
        assign src1[i] = (fwd_vs1 && wb_lane_mask[i]) ? wb_data[i] : bank_rd1[i];
        assign src2[i] = (fwd_vs2 && wb_lane_mask[i]) ? wb_data[i] : bank_rd2[i];
        assign v0_bits[i] = (fwd_v0 && wb_lane_mask[i]) ? wb_data[i][0] : bank_v0[i][0];

        assign op_b[i] = issue_use_scalar ? issue_scalar : src1[i];

        vector_lane_alu vector_lane_alu_i (
            .op     (issue_op),
            .op_a   (src2[i]),
            .op_b   (op_b[i]),
            .result (alu_res[i])
        );
    end

    vector_mask_unit vector_mask_unit_i (
        .vl           (vl),
        .mask_en      (issue_mask_en),
        .v0_bits      (v0_bits),
        .is_reduction (is_reduction),
        .lane_mask    (lane_mask),
        .reduce_mask  (reduce_mask)
    );

    vector_reduction vector_reduction_i (
        .lane_data (src2),
        .active    (reduce_mask),
        .seed      (issue_scalar),
        .sum       (red_sum)
    );

    always_comb begin
        lane_res = alu_res;
        if (is_reduction) begin
            lane_res[0] = red_sum;
        end
    end

    // result register holds while out_ready is low
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            run_q        <= 1'b0;
            wb_valid     <= 1'b0;
            wb_vd        <= '0;
            wb_data      <= '0;
            wb_lane_mask <= '0;
        end else begin
            run_q <= 1'b1;
            if (issue_ready) begin
                wb_valid <= issue_valid;
            end
            if (issue_fire) begin
                wb_vd        <= issue_vd;
                wb_data      <= lane_res;
                wb_lane_mask <= lane_mask;
            end
        end
    end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
) (
    output logic CLK,
    output logic rst_n
);

    initial begin
        CLK = 1'b0;
        forever begin
            #(period / 2) CLK = ~CLK;
        end
    end

    // release a little after the edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        #5 rst_n = 1'b1;
    end

endmodule

//--- test/vector_ex_assert.sv
module vector_ex_assert (
    input  logic                                     CLK,
    input  logic                                     rst_n,
    input  logic                                     issue_ready,
    input  logic                                     out_ready,
    input  logic                                     wb_valid,
    input  logic [vex_pkg::vreg_idx_w-1:0]           wb_vd,
    input  vex_pkg::word_t [vex_pkg::num_lanes-1:0]  wb_data,
    input  logic [vex_pkg::num_lanes-1:0]            wb_lane_mask
);

    // result register holds under back-pressure
    wb_hold_a: assert property (@(posedge CLK) disable iff (!rst_n)
        wb_valid && !out_ready |=> wb_valid && $stable(wb_vd) && $stable(wb_data)
            && $stable(wb_lane_mask))
        else $error("wb outputs changed while out_ready was low");

    wb_reset_a: assert property (@(posedge CLK) !rst_n |-> !wb_valid)
        else $error("wb_valid high during reset");

    // ready comes up one edge after release
    ready_a: assert property (@(posedge CLK) disable iff (!rst_n)
        $past(rst_n) |-> issue_ready == (!wb_valid || out_ready))
        else $error("issue_ready does not follow wb_valid and out_ready");

endmodule

bind vector_ex_datapath vector_ex_assert vector_ex_assert_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .issue_ready  (issue_ready),
    .out_ready    (out_ready),
    .wb_valid     (wb_valid),
    .wb_vd        (wb_vd),
    .wb_data      (wb_data),
    .wb_lane_mask (wb_lane_mask)
);

//--- test/vector_ex_tb.sv
module vector_ex_tb;

    import vex_pkg::*;

    localparam int clk_period = 40;

    typedef struct packed {
        vop_t                  op;
        logic [vreg_idx_w-1:0] vs1;
        logic [vreg_idx_w-1:0] vs2;
        logic [vreg_idx_w-1:0] vd;
        logic                  use_scalar;
        word_t                 scalar;
        logic                  mask_en;
        logic [vl_w-1:0]       vl;
        logic [3:0]            stall;
    } entry_t;

    typedef struct packed {
        logic [vreg_idx_w-1:0] vd;
        logic [num_lanes-1:0]  mask;
        word_t [num_lanes-1:0] data;
    } result_t;

    logic                  CLK;
    logic                  rst_n;
    logic                  issue_valid;
    logic                  issue_ready;
    vop_t                  issue_op;
    logic [vreg_idx_w-1:0] issue_vs1;
    logic [vreg_idx_w-1:0] issue_vs2;
    logic [vreg_idx_w-1:0] issue_vd;
    logic                  issue_use_scalar;
    word_t                 issue_scalar;
    logic                  issue_mask_en;
    logic [vl_w-1:0]       vl;
    logic                  wb_valid;
    logic [vreg_idx_w-1:0] wb_vd;
    word_t [num_lanes-1:0] wb_data;
    logic [num_lanes-1:0]  wb_lane_mask;
    logic                  out_ready;

    entry_t  tbl[$];
    result_t exp_q[$];
    word_t   model [num_vregs][num_lanes];
    int      idx;
    int      accepted;
    int      stall_left;
    int      timeout_cycles = 0;
    logic [31:0] lfsr_state;

    tb_clock_gen #(.period(clk_period), .reset_cycles(3)) tb_clock_gen_i (
        .CLK   (CLK),
        .rst_n (rst_n)
    );

    vector_ex_datapath vector_ex_datapath_i (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .issue_op         (issue_op),
        .issue_vs1        (issue_vs1),
        .issue_vs2        (issue_vs2),
        .issue_vd         (issue_vd),
        .issue_use_scalar (issue_use_scalar),
        .issue_scalar     (issue_scalar),
        .issue_mask_en    (issue_mask_en),
        .vl               (vl),
        .wb_valid         (wb_valid),
        .wb_vd            (wb_vd),
        .wb_data          (wb_data),
        .wb_lane_mask     (wb_lane_mask),
        .out_ready        (out_ready)
    );

    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input logic [num_lanes-1:0] got,
                              input logic [num_lanes-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vd(input string name, input logic [vreg_idx_w-1:0] got,
                            input logic [vreg_idx_w-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic push_entry(input vop_t op, input int vs1, input int vs2, input int vd,
                              input logic use_scalar, input word_t scalar,
                              input logic mask_en, input int vlen, input int stall);
        entry_t e;
        e.op = op;
        e.vs1 = vs1[vreg_idx_w-1:0];
        e.vs2 = vs2[vreg_idx_w-1:0];
        e.vd = vd[vreg_idx_w-1:0];
        e.use_scalar = use_scalar;
        e.scalar = scalar;
        e.mask_en = mask_en;
        e.vl = vlen[vl_w-1:0];
        e.stall = stall[3:0];
        tbl.push_back(e);
    endtask

    task automatic build_table();
        int max_stall;
        // op, vs1, vs2, vd, use_scalar, scalar, mask_en, vl, stall
        push_entry(vop_mv_x, 0, 0, 1, 1, rand_word(), 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 2, 1, rand_word(), 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 3, 1, 32'hffff_fff0, 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 4, 1, 32'd5, 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 5, 1, rand_word(), 0, 2, 1);
        // read back through or with the zero in v0
        push_entry(vop_or, 0, 1, 7, 0, 0, 0, 4, 0);
        push_entry(vop_or, 0, 2, 7, 0, 0, 0, 4, 2);
        push_entry(vop_or, 0, 5, 7, 0, 0, 0, 4, 0);
        push_entry(vop_add, 2, 1, 6, 0, 0, 0, 4, 0);
        push_entry(vop_sub, 2, 1, 6, 0, 0, 0, 4, 0);
        push_entry(vop_and, 2, 1, 6, 0, 0, 0, 4, 1);
        push_entry(vop_or, 1, 2, 6, 0, 0, 0, 4, 0);
        push_entry(vop_xor, 2, 1, 6, 0, 0, 0, 4, 0);
        push_entry(vop_seq, 1, 1, 6, 0, 0, 0, 4, 0);
        push_entry(vop_seq, 2, 1, 6, 0, 0, 0, 4, 0);
        push_entry(vop_slt, 4, 3, 6, 0, 0, 0, 4, 0);
        push_entry(vop_slt, 3, 4, 6, 0, 0, 0, 4, 0);
        push_entry(vop_slt, 0, 1, 6, 1, rand_word(), 0, 4, 0);
        push_entry(vop_add, 0, 2, 6, 1, rand_word(), 0, 3, 0);
        // v0 patterns used right away as the mask
        push_entry(vop_mv_x, 0, 0, 0, 1, 32'd1, 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 0, 1, 32'd2, 0, 1, 0);
        push_entry(vop_add, 2, 1, 3, 0, 0, 1, 3, 0);
        push_entry(vop_or, 0, 3, 7, 0, 0, 0, 4, 0);
        push_entry(vop_mv_x, 0, 0, 0, 1, 32'h10, 1, 3, 3);
        push_entry(vop_xor, 1, 2, 4, 0, 0, 1, 4, 0);
        push_entry(vop_or, 0, 4, 7, 0, 0, 0, 4, 0);
        push_entry(vop_redsum, 0, 1, 6, 1, rand_word(), 0, 4, 0);
        push_entry(vop_redsum, 0, 2, 6, 1, rand_word(), 1, 4, 2);
        push_entry(vop_redsum, 0, 6, 6, 1, 32'd7, 0, 3, 0);
        push_entry(vop_redsum, 0, 1, 5, 1, rand_word(), 0, 0, 0);
        // dependent chain through forwarding
        push_entry(vop_add, 1, 1, 2, 0, 0, 0, 4, 0);
        push_entry(vop_add, 2, 2, 2, 0, 0, 0, 4, 0);
        push_entry(vop_sub, 1, 2, 0, 0, 0, 0, 4, 0);
        push_entry(vop_add, 1, 2, 3, 0, 0, 1, 4, 0);
        push_entry(vop_or, 0, 3, 7, 0, 0, 0, 4, 4);
        max_stall = 0;
        foreach (tbl[i]) begin
            if (tbl[i].stall > max_stall) begin
                max_stall = tbl[i].stall;
            end
        end
        timeout_cycles = tbl.size() * (max_stall + 4) + 10;
    endtask

    task automatic predict(input entry_t e, output result_t r);
        logic [num_lanes-1:0] in_range;
        logic [num_lanes-1:0] active;
        word_t a;
        word_t b;
        word_t sum;
        r.vd = e.vd;
        sum = e.scalar;
        for (int l = 0; l < num_lanes; l++) begin
            in_range[l] = (l < e.vl);
            active[l] = in_range[l] && (!e.mask_en || model[0][l][0]);
            a = model[e.vs2][l];
            b = e.use_scalar ? e.scalar : model[e.vs1][l];
            case (e.op)
                vop_add: r.data[l] = a + b;
                vop_sub: r.data[l] = a - b;
                vop_and: r.data[l] = a & b;
                vop_or: r.data[l] = a | b;
                vop_xor: r.data[l] = a ^ b;
                vop_seq: r.data[l] = (a == b) ? 32'd1 : 32'd0;
                vop_slt: r.data[l] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                vop_mv_x: r.data[l] = b;
                default: r.data[l] = a;
            endcase
            if (active[l]) begin
                sum = sum + a;
            end
        end
        if (e.op == vop_redsum) begin
            r.mask = {3'b000, in_range[0]};
            r.data[0] = sum;
        end else begin
            r.mask = active;
        end
    endtask

    task automatic drive_cycle();
        entry_t e;
        if (idx < tbl.size()) begin
            e = tbl[idx];
            issue_valid = 1'b1;
            issue_op = e.op;
            issue_vs1 = e.vs1;
            issue_vs2 = e.vs2;
            issue_vd = e.vd;
            issue_use_scalar = e.use_scalar;
            issue_scalar = e.scalar;
            issue_mask_en = e.mask_en;
            vl = e.vl;
        end else begin
            issue_valid = 1'b0;
        end
        if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // mid-cycle when inputs and wb outputs have settled
    task automatic sample_cycle();
        result_t r;
        check_flag("issue_ready", issue_ready, (exp_q.size() == 0) || out_ready);
        if (wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("wb_valid went high with no instruction in flight");
                abort_run();
            end else begin
                r = exp_q[0];
                check_vd("wb_vd", wb_vd, r.vd);
                check_mask("wb_lane_mask", wb_lane_mask, r.mask);
                for (int l = 0; l < num_lanes; l++) begin
                    if (r.mask[l]) begin
                        check_word($sformatf("wb_data[%0d]", l), wb_data[l], r.data[l]);
                    end
                end
                if (out_ready) begin
                    for (int l = 0; l < num_lanes; l++) begin
                        if (r.mask[l]) begin
                            model[r.vd][l] = r.data[l];
                        end
                    end
                    void'(exp_q.pop_front());
                    accepted++;
                end
            end
        end else if (exp_q.size() != 0) begin
            $display("no result on wb one cycle after an accepted issue");
            abort_run();
        end
        if (issue_valid && issue_ready) begin
            predict(tbl[idx], r);
            exp_q.push_back(r);
            stall_left = tbl[idx].stall;
            idx++;
        end
    endtask

    initial begin
        wait (timeout_cycles > 0);
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run timed out", timeout_cycles);
        abort_run();
    end

    initial begin
        issue_valid = 1'b0;
        issue_op = vop_add;
        issue_vs1 = '0;
        issue_vs2 = '0;
        issue_vd = '0;
        issue_use_scalar = 1'b0;
        issue_scalar = '0;
        issue_mask_en = 1'b0;
        vl = '0;
        out_ready = 1'b1;
        idx = 0;
        accepted = 0;
        stall_left = 0;
        lfsr_state = 32'h4bc2c999;
        for (int r = 0; r < num_vregs; r++) begin
            for (int l = 0; l < num_lanes; l++) begin
                model[r][l] = '0;
            end
        end
        build_table();

        @(negedge CLK);
        while (!rst_n) begin
            check_flag("wb_valid", wb_valid, 1'b0);
            check_flag("issue_ready", issue_ready, 1'b0);
            @(negedge CLK);
        end
        // ready stays low until the first edge after release
        check_flag("issue_ready", issue_ready, 1'b0);

        while (accepted < tbl.size()) begin
            @(posedge CLK);
            #5;
            drive_cycle();
            @(negedge CLK);
            sample_cycle();
        end

        if (idx == tbl.size() && exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d issued but %0d results still pending", idx, exp_q.size());
            abort_run();
        end
    end

endmodule

//--- build.f
common/vex_pkg.sv
source/vector_bank.sv
source/vector_mask_unit.sv
execute/vector_lane_alu.sv
execute/vector_reduction.sv
execute/vector_ex_datapath.sv
test/tb_clock_gen.sv
test/vector_ex_assert.sv
test/vector_ex_tb.sv

//--- Bender.yml
package:
  name: vector_ex

sources:
  - common/vex_pkg.sv
  - source/vector_bank.sv
  - source/vector_mask_unit.sv
  - execute/vector_lane_alu.sv
  - execute/vector_reduction.sv
  - execute/vector_ex_datapath.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/vector_ex_assert.sv
      - test/vector_ex_tb.sv
